/* compile.f */
+incdir+design
design/cpu_bus_pkg.sv
design/axi_lite_pkg.sv
design/cpu_ctrl_sync.sv
design/cpu_cycle_capture.sv
design/cpu_axi_bridge.sv
design/axi_lite_ram.sv
design/cpu_subsystem_top.sv
testbench/tb_cpu_subsystem.sv

/* testbench/cpu_bus_cases.txt */
# kind addr(hex) data(hex) expected_read(hex) expected_stretch(0/1)
# R and W are one cpu bus cycle, IRQ and NMI pulse the interrupt input
W 0010 A5 00 0
R FFFC 00 00 0
R 0010 00 00 0
W 0100 11 00 0
W 0101 22 00 0
W 0102 33 00 0
W 0103 44 00 0
R 0100 00 11 0
R 0101 00 22 0
R 0102 00 33 0
R 0103 00 44 0
W 0206 5A 00 0
R 0204 00 00 0
R 0205 00 00 0
R 0206 00 5A 0
R 0207 00 00 0
W 0101 EE 00 0
R 0100 00 11 0
R 0101 00 EE 0
R 0102 00 33 0
R 0103 00 44 0
IRQ 0000 00 00 0
NMI 0000 00 00 0

/* testbench/tb_cpu_subsystem.sv */
`timescale 1ns/1ps
`include "bus_bridge_config.svh"
`default_nettype none

module tb_cpu_subsystem
    import cpu_bus_pkg::*;
();

    localparam int FAST_PERIOD = 4;
    // high phase of 16 fast cycles leaves room for the read path
    localparam int CPU_PERIOD = 128;
    localparam int RST_FAST_CYCLES = 8;
    localparam int SETTLE = 1;
    localparam int RAND_SEED = 32'h7048;
    localparam string CASE_FILE = "testbench/cpu_bus_cases.txt";

    logic i_clk_100;
    logic i_clk_cpu;
    logic i_rst;
    logic i_irq;
    logic i_nmi;
    logic i_cpu_rwb;
    logic i_cpu_sync;
    cpu_addr_t i_cpu_addr;
    cpu_byte_t i_cpu_data;
    logic o_cpu_rst;
    logic o_cpu_rdy;
    logic o_cpu_be;
    logic o_cpu_irqb;
    logic o_cpu_nmib;
    logic o_cpu_sob;
    cpu_byte_t o_cpu_data;

    string case_kind[$];
    cpu_addr_t case_addr[$];
    cpu_byte_t case_data[$];
    cpu_byte_t case_exp[$];
    bit case_stretch[$];

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    bit cases_loaded = 1'b0;
    bit rdy_low_seen = 1'b0;

    cpu_subsystem_top u_cpu_subsystem_top (
        .i_clk_100  (i_clk_100),
        .i_clk_cpu  (i_clk_cpu),
        .i_rst      (i_rst),
        .i_irq      (i_irq),
        .i_nmi      (i_nmi),
        .i_cpu_rwb  (i_cpu_rwb),
        .i_cpu_sync (i_cpu_sync),
        .i_cpu_addr (i_cpu_addr),
        .i_cpu_data (i_cpu_data),
        .o_cpu_rst  (o_cpu_rst),
        .o_cpu_rdy  (o_cpu_rdy),
        .o_cpu_be   (o_cpu_be),
        .o_cpu_irqb (o_cpu_irqb),
        .o_cpu_nmib (o_cpu_nmib),
        .o_cpu_sob  (o_cpu_sob),
        .o_cpu_data (o_cpu_data)
    );

    always #(FAST_PERIOD / 2) i_clk_100 = ~i_clk_100;
    always #(CPU_PERIOD / 2) i_clk_cpu = ~i_clk_cpu;

    // rdy sampled away from the fast rising edge
    always @(negedge i_clk_100) begin
        if (!o_cpu_rdy) begin
            rdy_low_seen = 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string label, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("%s: fail", label);
        end else begin
            $display("%s: pass", label);
        end
    endtask

    task automatic load_cases(output bit ok);
        int fd;
        int n;
        int c;
        int s;
        string tok;
        logic [15:0] a;
        logic [7:0] d;
        logic [7:0] e;
        ok = 1'b0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", CASE_FILE);
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                break;
            end
            if (tok.getc(0) == "#") begin
                // skip the rest of a comment line
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                n = $fscanf(fd, "%h %h %h %d", a, d, e, s);
                if (n != 4) begin
                    $display("malformed case line starting with %s", tok);
                    $fclose(fd);
                    return;
                end
                case_kind.push_back(tok);
                case_addr.push_back(a);
                case_data.push_back(d);
                case_exp.push_back(e);
                case_stretch.push_back(s != 0);
            end
        end
        $fclose(fd);
        ok = (case_kind.size() > 0);
        if (!ok) begin
            $display("case file holds no cases");
        end
    endtask

    // one cpu cycle, held while the bridge stretches it
    task automatic run_bus_cycle(input bit is_read, input cpu_addr_t addr,
                                 input cpu_byte_t wdata, output cpu_byte_t rdata,
                                 output bit stretched);
        int holds;
        holds = 0;
        @(posedge i_clk_cpu);
        #SETTLE;
        rdy_low_seen = 1'b0;
        i_cpu_rwb = is_read;
        i_cpu_addr = addr;
        i_cpu_data = is_read ? cpu_byte_t'($urandom) : wdata;
        @(negedge i_clk_cpu);
        while (!o_cpu_rdy && holds < 4) begin
            holds++;
            @(posedge i_clk_cpu);
            @(negedge i_clk_cpu);
        end
        rdata = o_cpu_data;
        stretched = rdy_low_seen;
    endtask

    function automatic logic int_line(input bit is_nmi);
        return is_nmi ? o_cpu_nmib : o_cpu_irqb;
    endfunction

    task automatic run_interrupt(input bit is_nmi);
        int waits;
        string name;
        name = is_nmi ? "o_cpu_nmib" : "o_cpu_irqb";
        @(posedge i_clk_cpu);
        #SETTLE;
        // bus idles on reads of address zero
        i_cpu_rwb = 1'b1;
        i_cpu_addr = '0;
        i_cpu_data = cpu_byte_t'($urandom);
        if (is_nmi) begin
            i_nmi = 1'b1;
        end else begin
            i_irq = 1'b1;
        end
        waits = 0;
        while (int_line(is_nmi) !== 1'b0 && waits < 3) begin
            @(posedge i_clk_cpu);
            #SETTLE;
            waits++;
        end
        check_value(name, int_line(is_nmi), 0);
        i_irq = 1'b0;
        i_nmi = 1'b0;
        waits = 0;
        while (int_line(is_nmi) !== 1'b1 && waits < 3) begin
            @(posedge i_clk_cpu);
            #SETTLE;
            waits++;
        end
        check_value(name, int_line(is_nmi), 1);
    endtask

    initial begin : watchdog
        longint limit_ns;
        wait (cases_loaded);
        limit_ns = longint'(case_kind.size()) * 20 * CPU_PERIOD
                 + RST_FAST_CYCLES * FAST_PERIOD
                 + (`BRIDGE_RST_CYCLES + 3) * CPU_PERIOD;
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit loaded;
        int waits;
        int errors_before;
        string label;
        cpu_byte_t rdata;
        bit stretched;
        i_clk_100 = 1'b0;
        i_clk_cpu = 1'b0;
        i_rst = 1'b0;
        i_irq = 1'b0;
        i_nmi = 1'b0;
        i_cpu_rwb = 1'b1;
        i_cpu_sync = 1'b0;
        i_cpu_addr = '0;
        i_cpu_data = '0;
        void'($urandom(RAND_SEED));
        load_cases(loaded);
        if (!loaded) begin
            errors++;
        end
        cases_loaded = loaded;

        #SETTLE;
        i_rst = 1'b1;
        errors_before = errors;
        repeat (RST_FAST_CYCLES) @(posedge i_clk_100);
        check_value("o_cpu_rst", o_cpu_rst, 0);
        #SETTLE;
        i_rst = 1'b0;
        waits = 0;
        while (o_cpu_rst !== 1'b1 && waits < `BRIDGE_RST_CYCLES + 3) begin
            @(posedge i_clk_cpu);
            #SETTLE;
            waits++;
        end
        check_value("o_cpu_rst", o_cpu_rst, 1);
        check_value("o_cpu_rdy", o_cpu_rdy, 1);
        check_value("o_cpu_irqb", o_cpu_irqb, 1);
        check_value("o_cpu_nmib", o_cpu_nmib, 1);
        // bus enable and set overflow are held inactive
        check_value("o_cpu_be", o_cpu_be, 1);
        check_value("o_cpu_sob", o_cpu_sob, 1);
        report_test("reset release", errors_before);

        for (int i = 0; i < case_kind.size(); i++) begin
            errors_before = errors;
            label = $sformatf("case %0d %s %04h", i, case_kind[i], case_addr[i]);
            if (case_kind[i] == "R" || case_kind[i] == "W") begin
                run_bus_cycle(case_kind[i] == "R", case_addr[i], case_data[i],
                              rdata, stretched);
                if (case_kind[i] == "R") begin
                    check_value("o_cpu_data", rdata, case_exp[i]);
                end
                check_value("o_cpu_rdy stretch", stretched, case_stretch[i]);
                check_value("o_cpu_rdy", o_cpu_rdy, 1);
            end else if (case_kind[i] == "IRQ") begin
                run_interrupt(1'b0);
            end else if (case_kind[i] == "NMI") begin
                run_interrupt(1'b1);
            end else begin
                $display("unknown case kind %s", case_kind[i]);
                errors++;
            end
            report_test(label, errors_before);
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/cpu_subsystem_top.sv */
`timescale 1ns/1ps
`include "bus_bridge_config.svh"
`default_nettype none

module cpu_subsystem_top
    import cpu_bus_pkg::*;
    import axi_lite_pkg::*;
(
    input  logic      i_clk_100,
    input  logic      i_clk_cpu,
    input  logic      i_rst,
    input  logic      i_irq,
    input  logic      i_nmi,
    input  logic      i_cpu_rwb,
    input  logic      i_cpu_sync,
    input  cpu_addr_t i_cpu_addr,
    input  cpu_byte_t i_cpu_data,
    output logic      o_cpu_rst,
    output logic      o_cpu_rdy,
    output logic      o_cpu_be,
    output logic      o_cpu_irqb,
    output logic      o_cpu_nmib,
    output logic      o_cpu_sob,
    output cpu_byte_t o_cpu_data
);

    logic cycle_valid;
    logic cycle_rwb;
    cpu_addr_t cycle_addr;
    logic wdata_valid;
    cpu_byte_t wdata;
    logic [7:0] phase_count;

    logic axi_awvalid;
    logic axi_awready;
    logic [`BRIDGE_ADDR_WIDTH-1:0] axi_awaddr;
    axi_prot_t axi_awprot;
    logic axi_wvalid;
    logic axi_wready;
    logic [`BRIDGE_DATA_WIDTH-1:0] axi_wdata;
    logic [`BRIDGE_DATA_WIDTH/8-1:0] axi_wstrb;
    logic axi_bvalid;
    logic axi_bready;
    axi_resp_t axi_bresp;
    logic axi_arvalid;
    logic axi_arready;
    logic [`BRIDGE_ADDR_WIDTH-1:0] axi_araddr;
    axi_prot_t axi_arprot;
    logic axi_rvalid;
    logic axi_rready;
    logic [`BRIDGE_DATA_WIDTH-1:0] axi_rdata;
    axi_resp_t axi_rresp;

    // bus always enabled, overflow never forced
    assign o_cpu_be = 1'b1;
    assign o_cpu_sob = 1'b1;

    cpu_ctrl_sync u_ctrl_sync (
        .i_clk_cpu  (i_clk_cpu),
        .i_rst      (i_rst),
        .i_irq      (i_irq),
        .i_nmi      (i_nmi),
        .o_cpu_rst  (o_cpu_rst),
        .o_cpu_irqb (o_cpu_irqb),
        .o_cpu_nmib (o_cpu_nmib)
    );

    cpu_cycle_capture u_cycle_capture (
        .i_clk_100     (i_clk_100),
        .i_rst         (i_rst),
        .i_clk_cpu     (i_clk_cpu),
        .i_cpu_rwb     (i_cpu_rwb),
        .i_cpu_sync    (i_cpu_sync),
        .i_cpu_addr    (i_cpu_addr),
        .i_cpu_data    (i_cpu_data),
        .o_cycle_valid (cycle_valid),
        .o_cycle_rwb   (cycle_rwb),
        .o_cycle_addr  (cycle_addr),
        .o_wdata_valid (wdata_valid),
        .o_wdata       (wdata),
        .o_phase_count (phase_count)
    );

    cpu_axi_bridge u_bridge (
        .i_clk_100     (i_clk_100),
        .i_rst         (i_rst),
        .i_cycle_valid (cycle_valid),
        .i_cycle_rwb   (cycle_rwb),
        .i_cycle_addr  (cycle_addr),
        .i_wdata_valid (wdata_valid),
        .i_wdata       (wdata),
        .i_phase_count (phase_count),
        .o_awvalid     (axi_awvalid),
        .i_awready     (axi_awready),
        .o_awaddr      (axi_awaddr),
        .o_awprot      (axi_awprot),
        .o_wvalid      (axi_wvalid),
        .i_wready      (axi_wready),
        .o_wdata       (axi_wdata),
        .o_wstrb       (axi_wstrb),
        .i_bvalid      (axi_bvalid),
        .o_bready      (axi_bready),
        .i_bresp       (axi_bresp),
        .o_arvalid     (axi_arvalid),
        .i_arready     (axi_arready),
        .o_araddr      (axi_araddr),
        .o_arprot      (axi_arprot),
        .i_rvalid      (axi_rvalid),
        .o_rready      (axi_rready),
        .i_rdata       (axi_rdata),
        .i_rresp       (axi_rresp),
        .o_cpu_rdy     (o_cpu_rdy),
        .o_cpu_data    (o_cpu_data)
    );

    axi_lite_ram u_ram (
        .i_clk_100 (i_clk_100),
        .i_rst     (i_rst),
        .i_awvalid (axi_awvalid),
        .o_awready (axi_awready),
        .i_awaddr  (axi_awaddr),
        .i_awprot  (axi_awprot),
        .i_wvalid  (axi_wvalid),
        .o_wready  (axi_wready),
        .i_wdata   (axi_wdata),
        .i_wstrb   (axi_wstrb),
        .o_bvalid  (axi_bvalid),
        .i_bready  (axi_bready),
        .o_bresp   (axi_bresp),
        .i_arvalid (axi_arvalid),
        .o_arready (axi_arready),
        .i_araddr  (axi_araddr),
        .i_arprot  (axi_arprot),
        .o_rvalid  (axi_rvalid),
        .i_rready  (axi_rready),
        .o_rdata   (axi_rdata),
        .o_rresp   (axi_rresp)
    );

endmodule

`default_nettype wire

/* design/axi_lite_ram.sv */
`timescale 1ns/1ps
`include "bus_bridge_config.svh"
`default_nettype none

module axi_lite_ram
    import axi_lite_pkg::*;
(
    input  logic      i_clk_100,
    input  logic      i_rst,
    input  logic      i_awvalid,
    output logic      o_awready,
    input  logic [`BRIDGE_ADDR_WIDTH-1:0] i_awaddr,
    input  axi_prot_t i_awprot,
    input  logic      i_wvalid,
    output logic      o_wready,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] i_wdata,
    input  logic [`BRIDGE_DATA_WIDTH/8-1:0] i_wstrb,
    output logic      o_bvalid,
    input  logic      i_bready,
    output axi_resp_t o_bresp,
    input  logic      i_arvalid,
    output logic      o_arready,
    input  logic [`BRIDGE_ADDR_WIDTH-1:0] i_araddr,
    input  axi_prot_t i_arprot,
    output logic      o_rvalid,
    input  logic      i_rready,
    output logic [`BRIDGE_DATA_WIDTH-1:0] o_rdata,
    output axi_resp_t o_rresp
);

    localparam int IDX_W = $clog2(`AXI_RAM_DEPTH_WORDS);
    localparam int LAT_W = $clog2(`AXI_RAM_READ_LATENCY + 1);
    localparam int STRB_W = `BRIDGE_DATA_WIDTH / 8;

    logic [`BRIDGE_DATA_WIDTH-1:0] mem [`AXI_RAM_DEPTH_WORDS];
    logic wr_fire;
    logic wr_ok;
    logic [IDX_W-1:0] wr_idx;
    logic rd_busy;
    logic rd_ok;
    logic rd_done;
    logic [IDX_W-1:0] rd_idx;
    logic [LAT_W-1:0] rd_cnt;

    // ram powers up cleared
    initial begin
        for (int i = 0; i < `AXI_RAM_DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // address and data are taken together
    assign wr_fire = i_awvalid && i_wvalid && !o_bvalid;
    assign o_awready = wr_fire;
    assign o_wready = wr_fire;
    assign wr_idx = i_awaddr[IDX_W+1:2];
    // non-secure accesses fall outside this ram
    assign wr_ok = !i_awprot[AXI_PROT_NONSECURE_BIT];
    assign o_arready = !rd_busy;
    assign rd_done = rd_busy && !o_rvalid && (rd_cnt == '0);

    always @(posedge i_clk_100) begin
        if (wr_fire && wr_ok) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
        if (rd_done) begin
            o_rdata <= rd_ok ? mem[rd_idx] : '0;
        end
    end

    always_ff @(posedge i_clk_100 or posedge i_rst) begin
        if (i_rst) begin
            o_bvalid <= 1'b0;
            o_bresp <= OKAY;
            rd_busy <= 1'b0;
            rd_ok <= 1'b0;
            rd_idx <= '0;
            rd_cnt <= '0;
            o_rvalid <= 1'b0;
            o_rresp <= OKAY;
        end else begin
            if (wr_fire) begin
                o_bvalid <= 1'b1;
                o_bresp <= wr_ok ? OKAY : DECERR;
            end else if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end

            // fixed latency from address accept to read valid
            if (i_arvalid && o_arready) begin
                rd_busy <= 1'b1;
                rd_idx <= i_araddr[IDX_W+1:2];
                rd_ok <= !i_arprot[AXI_PROT_NONSECURE_BIT];
                rd_cnt <= LAT_W'(`AXI_RAM_READ_LATENCY - 1);
            end else if (rd_done) begin
                o_rvalid <= 1'b1;
                o_rresp <= rd_ok ? OKAY : DECERR;
            end else if (rd_busy && !o_rvalid) begin
                rd_cnt <= rd_cnt - 1'b1;
            end else if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
                rd_busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cpu_axi_bridge.sv */
`timescale 1ns/1ps
`include "bus_bridge_config.svh"
`default_nettype none

module cpu_axi_bridge
    import cpu_bus_pkg::*;
    import axi_lite_pkg::*;
(
    input  logic      i_clk_100,
    input  logic      i_rst,
    input  logic      i_cycle_valid,
    input  logic      i_cycle_rwb,
    input  cpu_addr_t i_cycle_addr,
    input  logic      i_wdata_valid,
    input  cpu_byte_t i_wdata,
    input  logic [7:0] i_phase_count,
    output logic      o_awvalid,
    input  logic      i_awready,
    output logic [`BRIDGE_ADDR_WIDTH-1:0] o_awaddr,
    output axi_prot_t o_awprot,
    output logic      o_wvalid,
    input  logic      i_wready,
    output logic [`BRIDGE_DATA_WIDTH-1:0] o_wdata,
    output logic [`BRIDGE_DATA_WIDTH/8-1:0] o_wstrb,
    input  logic      i_bvalid,
    output logic      o_bready,
    input  axi_resp_t i_bresp,
    output logic      o_arvalid,
    input  logic      i_arready,
    output logic [`BRIDGE_ADDR_WIDTH-1:0] o_araddr,
    output axi_prot_t o_arprot,
    input  logic      i_rvalid,
    output logic      o_rready,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] i_rdata,
    input  axi_resp_t i_rresp,
    output logic      o_cpu_rdy,
    output cpu_byte_t o_cpu_data
);

    localparam int STRB_W = `BRIDGE_DATA_WIDTH / 8;

    bridge_state_t state;
    cpu_addr_t addr_q;
    logic rwb_q;
    cpu_byte_t wbyte_q;
    logic aw_done;
    logic w_done;
    logic [2:0] late_dly;
    logic stall_req;
    logic did_delay;
    logic [1:0] lane;
    logic [`BRIDGE_ADDR_WIDTH-1:0] word_addr;

    assign lane = addr_q[1:0];
    assign word_addr = `BRIDGE_ADDR_WIDTH'({addr_q[15:2], 2'b00});

    // a read answered after this point misses the cpu sample
    always_ff @(posedge i_clk_100 or posedge i_rst) begin
        if (i_rst) begin
            late_dly <= '0;
        end else begin
            late_dly <= {late_dly[1:0], (i_phase_count > 8'(`BRIDGE_MAX_DELAY))};
        end
    end

    assign stall_req = late_dly[2];

    assign o_awaddr = word_addr;
    assign o_araddr = word_addr;
    assign o_awprot = AXI_PROT_SECURE_DATA;
    assign o_arprot = AXI_PROT_SECURE_DATA;
    assign o_wstrb = STRB_W'(1) << lane;
    assign o_wdata = `BRIDGE_DATA_WIDTH'(wbyte_q) << {lane, 3'b000};
    assign o_awvalid = (state == WRITE_ADDR_DATA) && !aw_done;
    assign o_wvalid = (state == WRITE_ADDR_DATA) && !w_done;
    assign o_bready = (state == WRITE_RESP);
    assign o_arvalid = (state == READ_ADDR);
    assign o_rready = (state == READ_DATA);
    assign o_cpu_rdy = !did_delay;

    always_ff @(posedge i_clk_100 or posedge i_rst) begin
        if (i_rst) begin
            state <= RESET_WAIT;
            addr_q <= '0;
            rwb_q <= 1'b1;
            wbyte_q <= '0;
            aw_done <= 1'b0;
            w_done <= 1'b0;
            did_delay <= 1'b0;
            o_cpu_data <= '0;
        end else begin
            case (state)
                RESET_WAIT: begin
                    // cpu fetches its reset vector once out of reset
                    if (i_cycle_valid && (i_cycle_addr == `BRIDGE_RESET_VECTOR)) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (i_cycle_valid) begin
                        addr_q <= i_cycle_addr;
                        rwb_q <= i_cycle_rwb;
                        state <= ADDR_DECODE;
                    end
                end
                ADDR_DECODE: begin
                    state <= rwb_q ? READ_ADDR : WRITE_WAIT;
                end
                READ_ADDR: begin
                    if (i_arready) begin
                        state <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (stall_req) begin
                        did_delay <= 1'b1;
                    end
                    if (i_rvalid) begin
                        o_cpu_data <= i_rdata[{lane, 3'b000} +: 8];
                        state <= (did_delay || stall_req) ? STALL : IDLE;
                    end
                end
                WRITE_WAIT: begin
                    if (i_wdata_valid) begin
                        wbyte_q <= i_wdata;
                        state <= WRITE_ADDR_DATA;
                    end
                end
                WRITE_ADDR_DATA: begin
                    if (i_awready) begin
                        aw_done <= 1'b1;
                    end
                    if (i_wready) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || i_awready) && (w_done || i_wready)) begin
                        aw_done <= 1'b0;
                        w_done <= 1'b0;
                        state <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (i_bvalid) begin
                        state <= IDLE;
                    end
                end
                STALL: begin
                    // release rdy as the stretched cycle starts again
                    if (i_phase_count == 8'd1) begin
                        did_delay <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/cpu_cycle_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_cycle_capture
    import cpu_bus_pkg::*;
(
    input  logic      i_clk_100,
    input  logic      i_rst,
    input  logic      i_clk_cpu,
    input  logic      i_cpu_rwb,
    input  logic      i_cpu_sync,
    input  cpu_addr_t i_cpu_addr,
    input  cpu_byte_t i_cpu_data,
    output logic      o_cycle_valid,
    output logic      o_cycle_rwb,
    output cpu_addr_t o_cycle_addr,
    output logic      o_wdata_valid,
    output cpu_byte_t o_wdata,
    output logic [7:0] o_phase_count
);

    cpu_byte_t neg_data;
    logic [1:0] low_cnt;

    // write data is stable at the falling cpu clock
    always_ff @(negedge i_clk_cpu) begin
        neg_data <= i_cpu_data;
    end

    // cpu clock sampled as data, phase trusted after two stable cycles
    always_ff @(posedge i_clk_100 or posedge i_rst) begin
        if (i_rst) begin
            o_phase_count <= '0;
            low_cnt <= '0;
            o_cycle_valid <= 1'b0;
            o_cycle_rwb <= 1'b1;
            o_cycle_addr <= '0;
            o_wdata_valid <= 1'b0;
            o_wdata <= '0;
        end else begin
            o_cycle_valid <= 1'b0;
            if (i_clk_cpu) begin
                low_cnt <= '0;
                o_wdata_valid <= 1'b0;
                if (o_phase_count != 8'hFF) begin
                    o_phase_count <= o_phase_count + 1'b1;
                end
                if (o_phase_count == 8'd2) begin
                    o_cycle_valid <= 1'b1;
                    // opcode fetch is always a read
                    o_cycle_rwb <= i_cpu_rwb | i_cpu_sync;
                    o_cycle_addr <= i_cpu_addr;
                end
            end else begin
                o_phase_count <= '0;
                if (low_cnt != 2'd2) begin
                    low_cnt <= low_cnt + 1'b1;
                end else if (!o_wdata_valid) begin
                    o_wdata_valid <= 1'b1;
                    o_wdata <= neg_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/cpu_ctrl_sync.sv */
`timescale 1ns/1ps
`include "bus_bridge_config.svh"
`default_nettype none

module cpu_ctrl_sync (
    input  logic i_clk_cpu,
    input  logic i_rst,
    input  logic i_irq,
    input  logic i_nmi,
    output logic o_cpu_rst,
    output logic o_cpu_irqb,
    output logic o_cpu_nmib
);

    localparam int CNT_W = $clog2(`BRIDGE_RST_CYCLES + 1);
    // bit order is nmi, irq, reset release
    localparam logic [2:0] SYNC_RST_VAL = 3'b110;

    logic [CNT_W-1:0] rst_cnt;
    logic [2:0] sync_d;
    logic [2:0] sync_q1;
    logic [2:0] sync_q2;

    // keep the cpu in reset for a few of its own clocks
    always_ff @(posedge i_clk_cpu or posedge i_rst) begin
        if (i_rst) begin
            rst_cnt <= CNT_W'(`BRIDGE_RST_CYCLES);
        end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    assign sync_d = {~i_nmi, ~i_irq, (rst_cnt == '0)};

    // two flop synchronizers into the cpu domain
    always_ff @(posedge i_clk_cpu or posedge i_rst) begin
        if (i_rst) begin
            sync_q1 <= SYNC_RST_VAL;
            sync_q2 <= SYNC_RST_VAL;
        end else begin
            sync_q1 <= sync_d;
            sync_q2 <= sync_q1;
        end
    end

    assign o_cpu_rst = sync_q2[0];
    assign o_cpu_irqb = sync_q2[1];
    assign o_cpu_nmib = sync_q2[2];

endmodule

`default_nettype wire

/* design/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    typedef logic [2:0] axi_prot_t;

    // unprivileged, secure, data access
    localparam axi_prot_t AXI_PROT_SECURE_DATA = 3'b000;
    localparam int AXI_PROT_NONSECURE_BIT = 1;

endpackage

`default_nettype wire

/* design/cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

    // one cpu bus cycle in flight at a time
    typedef enum logic [3:0] {
        RESET_WAIT,
        IDLE,
        ADDR_DECODE,
        READ_ADDR,
        READ_DATA,
        WRITE_WAIT,
        WRITE_ADDR_DATA,
        WRITE_RESP,
        STALL
    } bridge_state_t;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0] cpu_byte_t;

endpackage

`default_nettype wire

/* design/bus_bridge_config.svh */
`ifndef BUS_BRIDGE_CONFIG_SVH
`define BUS_BRIDGE_CONFIG_SVH

// axi side of the bridge
`define BRIDGE_ADDR_WIDTH 32
`define BRIDGE_DATA_WIDTH 32

// fast cycles into the cpu high phase before a read is late
`define BRIDGE_MAX_DELAY 8
`define BRIDGE_RST_CYCLES 7
`define BRIDGE_RESET_VECTOR 16'hFFFC

`define AXI_RAM_DEPTH_WORDS 1024
`define AXI_RAM_READ_LATENCY 3

`endif
